// File: design/sensor_pkg.sv
// shared widths, register map, mode bits and pixel types, imported by every sensor channel block
package sensor_pkg;

    localparam int SENSOR_DATA_WIDTH = 12;              // sensor pixel bits
    localparam int OUT_WIDTH         = 16;              // memory word bits
    localparam int CMD_BYTES         = 6;               // AL, AH, D0..D3
    localparam int CMD_CNT_WIDTH     = $clog2(CMD_BYTES);
    localparam int FIFO_DEPTH_LOG2   = 4;
    localparam int FIFO_DEPTH        = 1 << FIFO_DEPTH_LOG2;

    typedef logic [SENSOR_DATA_WIDTH-1:0] pixel_t;
    typedef logic [OUT_WIDTH-1:0]         word_t;
    typedef logic [7:0]                   cmd_byte_t;
    typedef logic [15:0]                  cmd_addr_t;
    typedef logic [31:0]                  cmd_data_t;
    typedef logic [FIFO_DEPTH_LOG2:0]     fifo_ptr_t;  // extra msb tells full from empty
    typedef logic [2:0]                   pix_flags_t; // {sof, eol, eof}

    localparam cmd_addr_t SENSOR_CTRL_ADDR = 16'h0400; // channel mode register
    localparam cmd_addr_t SENSOR_CTRL_MASK = 16'h07ff; // address compare mask

    localparam int MODE_EN_BIT    = 8; // 1 enables the channel
    localparam int MODE_16BIT_BIT = 9; // 1 for 16 bpp, 0 for packed 8 bpp

    // positions inside pix_flags_t
    localparam int FLAG_SOF = 2;
    localparam int FLAG_EOL = 1;
    localparam int FLAG_EOF = 0;

    typedef enum logic [1:0] {
        FI_IDLE,       // waiting for vact low before arming
        FI_WAIT_FRAME, // vact low, waiting for the next rise
        FI_IN_FRAME    // accepting pixels of an enabled frame
    } fi_state_t;

    typedef enum logic {
        DS_IDLE,       // waiting for the strobe with AL
        DS_COLLECT     // receiving AH and D0..D3
    } deser_state_t;

endpackage

// File: design/sensor_cmd_deser.sv
// byte-serial command receiver; writes chn_en and bit16 from commands hitting the mode register
`timescale 1ns/1ps

module sensor_cmd_deser (
    input  logic                 mclk,
    input  logic                 mrst,
    input  sensor_pkg::cmd_byte_t cmd_ad_i,  // AL with the strobe, then AH, D0..D3
    input  logic                 cmd_stb_i,
    output logic                 chn_en_o,
    output logic                 bit16_o
);
    import sensor_pkg::*;

    deser_state_t             state;
    logic [CMD_CNT_WIDTH-1:0] byte_cnt;  // index of the byte now on cmd_ad_i
    cmd_addr_t                addr_r;    // AH:AL
    logic [23:0]              data_r;    // D2:D1:D0, D3 comes with the last byte
    cmd_data_t                wr_data;
    logic                     addr_hit;
    logic                     last_byte;

    assign last_byte = (state == DS_COLLECT) && (byte_cnt == CMD_CNT_WIDTH'(CMD_BYTES - 1));
    assign wr_data   = {cmd_ad_i, data_r};                               // full word at D3
    assign addr_hit  = (addr_r & SENSOR_CTRL_MASK) == (SENSOR_CTRL_ADDR & SENSOR_CTRL_MASK);

    always_ff @(posedge mclk) begin
        if (mrst) begin
            state    <= DS_IDLE;
            byte_cnt <= '0;
            chn_en_o <= 1'b0;
            bit16_o  <= 1'b0;
        end else begin
            case (state)
                DS_IDLE: begin
                    if (cmd_stb_i) begin
                        state    <= DS_COLLECT;
                        byte_cnt <= CMD_CNT_WIDTH'(1); // AL taken now, AH next
                    end
                end
                DS_COLLECT: begin
                    byte_cnt <= byte_cnt + 1'b1;
                    if (last_byte) begin
                        state <= DS_IDLE;
                        if (addr_hit) begin          // other addresses belong to other blocks
                            chn_en_o <= wr_data[MODE_EN_BIT];
                            bit16_o  <= wr_data[MODE_16BIT_BIT];
                        end
                    end
                end
                default: state <= DS_IDLE;
            endcase
        end
    end

    // address and data shift registers, lsb byte first
    always_ff @(posedge mclk) begin
        if (state == DS_IDLE && cmd_stb_i) begin
            addr_r <= {cmd_ad_i, addr_r[15:8]};          // AL
        end else if (state == DS_COLLECT && byte_cnt == CMD_CNT_WIDTH'(1)) begin
            addr_r <= {cmd_ad_i, addr_r[15:8]};          // AH
        end else if (state == DS_COLLECT && !last_byte) begin
            data_r <= {cmd_ad_i, data_r[23:8]};          // D0..D2
        end
    end

endmodule

// File: design/sensor_frame_in.sv
// sensor front end; finds frame and line edges and pushes each pixel with its sof/eol/eof flags
`timescale 1ns/1ps

module sensor_frame_in (
    input  logic                   mclk,
    input  logic                   mrst,
    input  sensor_pkg::pixel_t     pxd_i,
    input  logic                   vact_i,       // frame active
    input  logic                   hact_i,       // line active, one pixel per cycle
    input  logic                   chn_en_i,     // sampled at vact rise
    input  logic                   full_i,
    output logic                   push_o,
    output sensor_pkg::pixel_t     push_pix_o,
    output sensor_pkg::pix_flags_t push_flags_o, // {sof, eol, eof}
    output logic                   overflow_o    // sticky, a pixel was lost
);
    import sensor_pkg::*;

    fi_state_t state;
    pixel_t    hold_pix;   // pixel waiting for its flags
    logic      hold_valid;
    logic      hold_sof;   // held pixel opens the frame
    logic      hold_eol;   // hact fell after the held pixel
    logic      first_pend; // no pixel yet in this frame

    always_ff @(posedge mclk) begin
        if (mrst) begin
            state      <= FI_IDLE;
            hold_valid <= 1'b0;
            hold_sof   <= 1'b0;
            hold_eol   <= 1'b0;
            first_pend <= 1'b0;
            push_o     <= 1'b0;
            overflow_o <= 1'b0;
        end else begin
            push_o <= 1'b0;
            if (push_o && full_i) overflow_o <= 1'b1;      // fifo drops this push
            case (state)
                FI_IDLE: begin
                    if (!vact_i) state <= FI_WAIT_FRAME; // never start mid-frame
                end
                FI_WAIT_FRAME: begin
                    if (vact_i) begin
                        state      <= chn_en_i ? FI_IN_FRAME : FI_IDLE; // disabled: skip frame
                        first_pend <= chn_en_i;
                    end
                end
                FI_IN_FRAME: begin
                    if (!vact_i) begin                   // frame end flushes the hold
                        push_o     <= hold_valid;
                        hold_valid <= 1'b0;
                        state      <= FI_WAIT_FRAME;
                    end else if (hact_i) begin           // new pixel settles the held one
                        push_o     <= hold_valid;
                        hold_valid <= 1'b1;
                        hold_sof   <= first_pend;
                        hold_eol   <= 1'b0;
                        first_pend <= 1'b0;
                    end else if (hold_valid) begin
                        hold_eol <= 1'b1;                // line gap after held pixel
                    end
                end
                default: state <= FI_IDLE;
            endcase
        end
    end

    // hold and push payload
    always_ff @(posedge mclk) begin
        if (state == FI_IN_FRAME) begin
            push_pix_o   <= hold_pix;
            push_flags_o <= vact_i ? {hold_sof, hold_eol, 1'b0} : {hold_sof, 2'b11};
            if (vact_i && hact_i) hold_pix <= pxd_i;
        end
    end

endmodule

// File: design/sensor_pixel_fifo.sv
// 16-entry synchronous FIFO of flagged pixels between the front end and the packer
`timescale 1ns/1ps

module sensor_pixel_fifo (
    input  logic                   mclk,
    input  logic                   mrst,
    input  logic                   push_i,
    input  sensor_pkg::pixel_t     push_pix_i,
    input  sensor_pkg::pix_flags_t push_flags_i,
    input  logic                   pop_ready_i,
    output logic                   full_o,
    output logic                   pop_valid_o,
    output sensor_pkg::pixel_t     pop_pix_o,
    output sensor_pkg::pix_flags_t pop_flags_o
);
    import sensor_pkg::*;

    pixel_t     pix_mem  [FIFO_DEPTH];
    pix_flags_t flag_mem [FIFO_DEPTH];
    fifo_ptr_t  wr_ptr;
    fifo_ptr_t  rd_ptr;
    logic       do_push;
    logic       do_pop;

    // same index, different wrap bit
    assign full_o = (wr_ptr[FIFO_DEPTH_LOG2] != rd_ptr[FIFO_DEPTH_LOG2]) &&
                    (wr_ptr[FIFO_DEPTH_LOG2-1:0] == rd_ptr[FIFO_DEPTH_LOG2-1:0]);
    assign pop_valid_o = (wr_ptr != rd_ptr);           // not empty
    assign do_push     = push_i && !full_o;            // push while full is lost
    assign do_pop      = pop_valid_o && pop_ready_i;

    // asynchronous read, entry shows the cycle after its push
    assign pop_pix_o   = pix_mem[rd_ptr[FIFO_DEPTH_LOG2-1:0]];
    assign pop_flags_o = flag_mem[rd_ptr[FIFO_DEPTH_LOG2-1:0]];

    always_ff @(posedge mclk) begin
        if (do_push) begin
            pix_mem[wr_ptr[FIFO_DEPTH_LOG2-1:0]]  <= push_pix_i;
            flag_mem[wr_ptr[FIFO_DEPTH_LOG2-1:0]] <= push_flags_i;
        end
    end

    always_ff @(posedge mclk) begin
        if (mrst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
        end
    end

endmodule

// File: design/sensor_out_packer.sv
// output packer; turns FIFO pixels into 16-bit memory words, one pixel or two packed bytes each
`timescale 1ns/1ps

module sensor_out_packer (
    input  logic                   mclk,
    input  logic                   mrst,
    input  logic                   bit16_i,       // sampled with the sof pixel
    input  logic                   pop_valid_i,
    input  sensor_pkg::pixel_t     pop_pix_i,
    input  sensor_pkg::pix_flags_t pop_flags_i,
    input  logic                   dout_ready_i,
    output logic                   pop_ready_o,
    output sensor_pkg::word_t      dout_o,
    output logic                   dout_valid_o,
    output logic                   last_in_line_o,
    output logic                   sof_o,
    output logic                   eof_o
);
    import sensor_pkg::*;

    logic       mode16_r;   // mode of the current frame
    logic       low_valid;  // 8-bit mode, low byte waiting for a partner
    logic [7:0] low_byte;
    logic       low_sof;    // low byte came from the sof pixel
    logic       pop_fire;
    logic       mode16_now;
    logic       emit;       // this pop completes a word
    logic [7:0] byte_hi;
    word_t      word_next;
    logic       sof_next;

    assign pop_ready_o = !dout_valid_o || dout_ready_i; // output free or leaving
    assign pop_fire    = pop_valid_i && pop_ready_o;
    assign mode16_now  = pop_flags_i[FLAG_SOF] ? bit16_i : mode16_r;
    assign byte_hi     = pop_pix_i[SENSOR_DATA_WIDTH-1 -: 8];

    always_comb begin
        if (mode16_now) begin
            emit      = 1'b1;
            word_next = {pop_pix_i, {(OUT_WIDTH - SENSOR_DATA_WIDTH){1'b0}}}; // left aligned
            sof_next  = pop_flags_i[FLAG_SOF];
        end else if (low_valid) begin
            emit      = 1'b1;
            word_next = {byte_hi, low_byte};     // earlier pixel in low byte
            sof_next  = low_sof;
        end else begin
            emit      = pop_flags_i[FLAG_EOL];   // odd line end, high byte empty
            word_next = {8'h00, byte_hi};
            sof_next  = pop_flags_i[FLAG_SOF];
        end
    end

    always_ff @(posedge mclk) begin
        if (mrst) begin
            dout_valid_o <= 1'b0;
            low_valid    <= 1'b0;
            mode16_r     <= 1'b0;
        end else if (pop_fire) begin
            dout_valid_o <= emit;
            if (pop_flags_i[FLAG_SOF]) mode16_r <= bit16_i;
            if (!mode16_now) low_valid <= !low_valid && !pop_flags_i[FLAG_EOL];
        end else if (dout_ready_i) begin
            dout_valid_o <= 1'b0;                // word taken, nothing new
        end
    end

    always_ff @(posedge mclk) begin
        if (pop_fire && emit) begin
            dout_o         <= word_next;
            sof_o          <= sof_next;
            last_in_line_o <= pop_flags_i[FLAG_EOL];
            eof_o          <= pop_flags_i[FLAG_EOF];
        end
        if (pop_fire && !mode16_now && !low_valid) begin
            low_byte <= byte_hi;
            low_sof  <= pop_flags_i[FLAG_SOF];
        end
    end

endmodule

// File: design/sensor_channel.sv
// sensor channel top; registers the ports and joins command path, front end, FIFO and packer
`timescale 1ns/1ps

module sensor_channel (
    input  logic                  mclk,
    input  logic                  mrst,
    input  sensor_pkg::cmd_byte_t cmd_ad_i,
    input  logic                  cmd_stb_i,
    input  sensor_pkg::pixel_t    pxd_i,
    input  logic                  vact_i,
    input  logic                  hact_i,
    input  logic                  dout_ready_i,  // memory side takes dout_o
    output sensor_pkg::word_t     dout_o,
    output logic                  dout_valid_o,
    output logic                  last_in_line_o,
    output logic                  sof_o,
    output logic                  eof_o,
    output logic                  overflow_o
);
    import sensor_pkg::*;

    cmd_byte_t  cmd_ad_r;
    logic       cmd_stb_r;
    pixel_t     pxd_r;
    logic       vact_r;
    logic       hact_r;
    logic       chn_en;
    logic       bit16;
    logic       push;
    pixel_t     push_pix;
    pix_flags_t push_flags;
    logic       fifo_full;
    logic       pop_valid;
    logic       pop_ready;
    pixel_t     pop_pix;
    pix_flags_t pop_flags;

    always_ff @(posedge mclk) begin
        cmd_ad_r <= cmd_ad_i;
        pxd_r    <= pxd_i;
        if (mrst) begin
            cmd_stb_r <= 1'b0;
            vact_r    <= 1'b0;
            hact_r    <= 1'b0;
        end else begin
            cmd_stb_r <= cmd_stb_i;
            vact_r    <= vact_i;
            hact_r    <= hact_i;
        end
    end

    sensor_cmd_deser sensor_cmd_deser_inst (
        .mclk(mclk), .mrst(mrst),
        .cmd_ad_i(cmd_ad_r), .cmd_stb_i(cmd_stb_r),
        .chn_en_o(chn_en), .bit16_o(bit16)
    );

    sensor_frame_in sensor_frame_in_inst (
        .mclk(mclk), .mrst(mrst),
        .pxd_i(pxd_r), .vact_i(vact_r), .hact_i(hact_r),
        .chn_en_i(chn_en), .full_i(fifo_full),
        .push_o(push), .push_pix_o(push_pix), .push_flags_o(push_flags),
        .overflow_o(overflow_o)
    );

    sensor_pixel_fifo sensor_pixel_fifo_inst (
        .mclk(mclk), .mrst(mrst),
        .push_i(push), .push_pix_i(push_pix), .push_flags_i(push_flags),
        .pop_ready_i(pop_ready), .full_o(fifo_full),
        .pop_valid_o(pop_valid), .pop_pix_o(pop_pix), .pop_flags_o(pop_flags)
    );

    sensor_out_packer sensor_out_packer_inst (
        .mclk(mclk), .mrst(mrst), .bit16_i(bit16),
        .pop_valid_i(pop_valid), .pop_pix_i(pop_pix), .pop_flags_i(pop_flags),
        .dout_ready_i(dout_ready_i), .pop_ready_o(pop_ready),
        .dout_o(dout_o), .dout_valid_o(dout_valid_o),
        .last_in_line_o(last_in_line_o), .sof_o(sof_o), .eof_o(eof_o)
    );

endmodule

// File: dv/sensor_channel_assert.sv
// bind-attached checks of the FIFO and output handshakes and of the sticky overflow flag
`timescale 1ns/1ps

module sensor_channel_assert (
    input logic                   mclk,
    input logic                   mrst,
    input logic                   push,          // front end to FIFO
    input logic                   pop_valid,     // FIFO not empty
    input logic                   pop_ready,
    input sensor_pkg::pixel_t     pop_pix,
    input sensor_pkg::pix_flags_t pop_flags,
    input logic                   dout_valid_o,
    input logic                   dout_ready_i,
    input sensor_pkg::word_t      dout_o,
    input logic                   sof_o,
    input logic                   last_in_line_o,
    input logic                   eof_o,
    input logic                   overflow_o
);

    fifo_head_holds: assert property (@(posedge mclk) disable iff (mrst)
        pop_valid && !pop_ready |=> pop_valid && $stable(pop_pix) && $stable(pop_flags))
        else $error("FIFO head changed or vanished before the packer took it");

    // an empty FIFO only turns valid through a push, so a pop never runs it below empty
    no_pop_when_empty: assert property (@(posedge mclk) disable iff (mrst)
        !pop_valid && !push |=> !pop_valid)
        else $error("FIFO became valid without a push, read pointer passed write pointer");

    dout_holds: assert property (@(posedge mclk) disable iff (mrst)
        dout_valid_o && !dout_ready_i |=> dout_valid_o && $stable(dout_o)
            && $stable({sof_o, last_in_line_o, eof_o}))
        else $error("output word or flags changed while waiting for ready");

    overflow_sticky: assert property (@(posedge mclk) disable iff (mrst)
        overflow_o |=> overflow_o)
        else $error("overflow flag cleared without reset");

endmodule

// File: dv/tb_sensor_channel.sv
// table-driven testbench for the sensor channel; writes the mode, sends frames, checks every word
`timescale 1ns/1ps

module tb_sensor_channel;
    import sensor_pkg::*;

    localparam logic [31:0] SEED       = 32'h8b29;
    localparam int          TIMEOUT    = 2000;     // cycles per wait
    localparam int          QUIET      = 40;       // idle cycles to catch stray words
    localparam int          LINE_GAP   = 4;        // hact low between lines
    localparam logic [1:0]  RDY_ALWAYS = 2'd0;
    localparam logic [1:0]  RDY_RANDOM = 2'd1;
    localparam logic [1:0]  RDY_LOW    = 2'd2;
    localparam int          NUM_ROWS   = 8;

    typedef struct packed {
        logic [1:0]  mode;      // {16bit, enable}
        logic [15:0] addr;      // command address
        int          width;     // pixels per line
        int          lines;
        logic [1:0]  rdy;       // dout_ready_i pattern
        int          exp_words;
        logic        exp_ovf;
    } row_t;

    localparam row_t ROWS [NUM_ROWS] = '{
        '{2'b11, 16'h0400, 6, 3, RDY_ALWAYS, 18, 1'b0}, // 16 bpp
        '{2'b01, 16'h0400, 6, 2, RDY_ALWAYS, 6, 1'b0},  // 8 bpp, even lines
        '{2'b01, 16'h0400, 5, 3, RDY_ALWAYS, 9, 1'b0},  // 8 bpp, odd lines
        '{2'b10, 16'h0400, 4, 2, RDY_ALWAYS, 0, 1'b0},  // channel off
        '{2'b11, 16'h0500, 4, 2, RDY_ALWAYS, 0, 1'b0},  // other register, stays off
        '{2'b01, 16'h8400, 3, 3, RDY_RANDOM, 6, 1'b0},  // upper address bits masked
        '{2'b11, 16'h0400, 5, 3, RDY_RANDOM, 15, 1'b0}, // fits the FIFO
        '{2'b11, 16'h0400, 8, 4, RDY_LOW, 0, 1'b1}      // 32 pixels into 16 entries
    };

    logic        mclk = 1'b0;
    logic        mrst;
    cmd_byte_t   cmd_ad_i;
    logic        cmd_stb_i;
    pixel_t      pxd_i;
    logic        vact_i;
    logic        hact_i;
    logic        dout_ready_i = 1'b0;
    word_t       dout_o;
    logic        dout_valid_o;
    logic        last_in_line_o;
    logic        sof_o;
    logic        eof_o;
    logic        overflow_o;

    logic [1:0]  ready_mode = RDY_ALWAYS;
    logic [31:0] rng_rdy = SEED;
    logic [31:0] rng_pix = SEED;
    logic [1:0]  cur_mode = 2'b00;      // model of the mode register
    pixel_t      pix [$];               // pixels of the current frame
    logic [18:0] exp_q [$];             // {sof, eol, eof, word}
    int          accepted = 0;          // words taken in this row
    int          total_words = 0;
    int          value_errs = 0;
    int          other_errs = 0;

    sensor_channel sensor_channel_inst (
        .mclk(mclk), .mrst(mrst), .cmd_ad_i(cmd_ad_i), .cmd_stb_i(cmd_stb_i),
        .pxd_i(pxd_i), .vact_i(vact_i), .hact_i(hact_i), .dout_ready_i(dout_ready_i),
        .dout_o(dout_o), .dout_valid_o(dout_valid_o), .last_in_line_o(last_in_line_o),
        .sof_o(sof_o), .eof_o(eof_o), .overflow_o(overflow_o)
    );

    bind sensor_channel sensor_channel_assert sensor_channel_assert_inst (
        .mclk(mclk), .mrst(mrst), .push(push), .pop_valid(pop_valid), .pop_ready(pop_ready),
        .pop_pix(pop_pix), .pop_flags(pop_flags), .dout_valid_o(dout_valid_o),
        .dout_ready_i(dout_ready_i), .dout_o(dout_o), .sof_o(sof_o),
        .last_in_line_o(last_in_line_o), .eof_o(eof_o), .overflow_o(overflow_o)
    );

    always #5 mclk = ~mclk;             // 10 ns period

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic compare_field(input string name, input int exp_v, input int act_v);
        assert (act_v == exp_v) else begin
            $display("[FAIL] %0t %s expected %0h actual %0h", $time, name, exp_v, act_v);
            value_errs++;
        end
    endtask

    task automatic write_cmd(input logic [15:0] addr, input logic [1:0] mode);
        logic [31:0] data;
        cmd_byte_t   bytes [CMD_BYTES];
        data = '0;
        data[MODE_EN_BIT] = mode[0];
        data[MODE_16BIT_BIT] = mode[1];
        bytes = '{addr[7:0], addr[15:8], data[7:0], data[15:8], data[23:16], data[31:24]};
        for (int k = 0; k < CMD_BYTES; k++) begin
            cmd_stb_i = (k == 0);       // strobe marks AL
            cmd_ad_i  = bytes[k];
            @(negedge mclk);
        end
        cmd_stb_i = 1'b0;
        cmd_ad_i  = '0;
        repeat (4) @(negedge mclk);     // input register plus 2 cycles to the mode bits
    endtask

    task automatic make_frame(input int w, input int l);
        pix.delete();
        for (int k = 0; k < w * l; k++) begin
            rng_pix = xorshift(rng_pix);
            pix.push_back(rng_pix[SENSOR_DATA_WIDTH-1:0]);
        end
    endtask

    task automatic expect_frame(input int w, input int l, input logic b16);
        pixel_t p0;
        pixel_t p1;
        logic   last;
        int     x;
        for (int y = 0; y < l; y++) begin
            x = 0;
            while (x < w) begin
                p0 = pix[y * w + x];
                if (b16) begin
                    last = (x == w - 1);
                    exp_q.push_back({y == 0 && x == 0, last, last && y == l - 1, p0, 4'h0});
                    x = x + 1;
                end else begin
                    last = (x + 2 >= w);        // pair closes the line or odd tail
                    p1 = (x + 1 < w) ? pix[y * w + x + 1] : '0;
                    exp_q.push_back({y == 0 && x == 0, last, last && y == l - 1,
                                     p1[SENSOR_DATA_WIDTH-1 -: 8], p0[SENSOR_DATA_WIDTH-1 -: 8]});
                    x = x + 2;
                end
            end
        end
    endtask

    task automatic send_frame(input int w, input int l);
        vact_i = 1'b0;
        hact_i = 1'b0;
        repeat (4) @(negedge mclk);
        vact_i = 1'b1;
        repeat (3) @(negedge mclk);     // blanking before the first line
        for (int y = 0; y < l; y++) begin
            for (int x = 0; x < w; x++) begin
                hact_i = 1'b1;
                pxd_i  = pix[y * w + x];
                @(negedge mclk);
            end
            hact_i = 1'b0;
            repeat (LINE_GAP) @(negedge mclk);
        end
        vact_i = 1'b0;
        repeat (4) @(negedge mclk);
    endtask

    task automatic wait_words(input int target);
        int n;
        n = 0;
        while (accepted < target && n < TIMEOUT) begin
            @(negedge mclk);
            n++;
        end
        assert (accepted >= target) else begin
            $display("%0t: timed out, only %0d of %0d words came out", $time, accepted, target);
            other_errs++;
        end
    endtask

    task automatic pulse_reset();
        mrst = 1'b1;
        repeat (16) @(negedge mclk);
        mrst = 1'b0;
    endtask

    always @(negedge mclk) begin
        rng_rdy = xorshift(rng_rdy);
        case (ready_mode)
            RDY_ALWAYS: dout_ready_i = 1'b1;
            RDY_RANDOM: dout_ready_i = rng_rdy[3];
            default:    dout_ready_i = 1'b0;
        endcase
    end

    always @(posedge mclk) begin : word_monitor
        logic [18:0] e;
        if (!mrst && dout_valid_o && dout_ready_i) begin
            accepted++;
            total_words++;
            assert (exp_q.size() > 0) else begin
                $display("%0t: word %h came out while none was expected", $time, dout_o);
                other_errs++;
            end
            if (exp_q.size() > 0) begin
                e = exp_q.pop_front();
                compare_field("dout_o", int'(e[15:0]), int'(dout_o));
                compare_field("sof_o", int'(e[18]), int'(sof_o));
                compare_field("last_in_line_o", int'(e[17]), int'(last_in_line_o));
                compare_field("eof_o", int'(e[16]), int'(eof_o));
            end
        end
    end

    initial begin : main_seq
        row_t r;
        mrst      = 1'b1;
        cmd_ad_i  = '0;
        cmd_stb_i = 1'b0;
        pxd_i     = '0;
        vact_i    = 1'b0;
        hact_i    = 1'b0;
        repeat (16) @(negedge mclk);
        mrst = 1'b0;
        for (int i = 0; i < NUM_ROWS; i++) begin
            r = ROWS[i];
            ready_mode = r.rdy;
            accepted = 0;
            write_cmd(r.addr, r.mode);
            if ((r.addr & SENSOR_CTRL_MASK) == SENSOR_CTRL_ADDR) cur_mode = r.mode;
            make_frame(r.width, r.lines);
            if (cur_mode[0]) expect_frame(r.width, r.lines, cur_mode[1]);
            send_frame(r.width, r.lines);
            wait_words(r.exp_words);
            repeat (QUIET) @(negedge mclk);
            compare_field("word count", r.exp_words, accepted);
            compare_field("overflow_o", int'(r.exp_ovf), int'(overflow_o));
            if (r.exp_ovf) begin
                pulse_reset();          // flushes the stuck words too
                exp_q.delete();
                cur_mode = 2'b00;
                compare_field("overflow_o", 0, int'(overflow_o));
            end else begin
                assert (exp_q.size() == 0) else begin
                    $display("%0t: row %0d left %0d expected words unseen", $time, i, exp_q.size());
                    other_errs++;
                end
            end
        end
        $display("summary: %0d words checked, %0d value errors, %0d other errors",
                 total_words, value_errs, other_errs);
        if (value_errs + other_errs == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: flist.f
design/sensor_pkg.sv
design/sensor_cmd_deser.sv
design/sensor_frame_in.sv
design/sensor_pixel_fifo.sv
design/sensor_out_packer.sv
design/sensor_channel.sv
dv/sensor_channel_assert.sv
dv/tb_sensor_channel.sv

// File: run.sh
#!/bin/sh
# build and run the sensor channel testbench with Verilator, decide pass/fail from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_sensor_channel -f flist.f -o tb_sim \
    && ./obj_dir/tb_sim > sim.log 2>&1

cat sim.log 2>/dev/null
grep -qx "TESTS PASSED" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
